//--- src.f
source/lbm_lattice_pkg.sv
source/lbm_ctrl_pkg.sv
source/lbm_step_fsm.sv
source/cell_scan_counter.sv
source/stream_bounce_unit.sv
source/lattice_memory.sv
source/lbm_solver.sv
tb/lbm_solver_chk.sv
tb/lbm_solver_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := lbm_solver_tb
FILELIST  := src.f
BUILD_DIR := obj_dir
BIN       := $(BUILD_DIR)/V$(TOP)
RUN_FLAGS := +verilator+error+limit+1000
LOG       := sim.log
FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BIN) $(RUN_FLAGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "run ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/lbm_solver_tb.sv
`timescale 1ns/1ps

module lbm_solver_tb;
    import lbm_lattice_pkg::*;
    import lbm_ctrl_pkg::*;

    localparam int grid_width  = 8;
    localparam int grid_height = 8;
    localparam int cells       = grid_width * grid_height;
    localparam int addr_width  = $clog2(cells);

    // run length covers init + 1 + 3 + 1 + 1 passes and five full read-backs
    localparam int total_passes   = 7;
    localparam int read_backs     = 5;
    localparam int timeout_cycles = 2 * (total_passes * (cells + 3) + read_backs * (cells + 2));

    // direction steps with north as the row above
    localparam int ref_dx [9] = '{0, 0, 1, 1, 1, 0, -1, -1, -1};
    localparam int ref_dy [9] = '{0, -1, -1, 0, 1, 1, 1, 0, -1};

    typedef cell_pops_u [cells-1:0] grid_t;

    logic                  clk;
    logic                  rst_n;
    cmd_t                  cmd;
    logic                  ready;
    logic                  busy;
    logic                  done;
    logic [cells-1:0]      barriers;
    cell_pops_u            init_pops;
    logic [addr_width-1:0] rd_addr;
    cell_pops_u            rd_data;

    grid_t                 model;
    logic                  rd_req;
    logic                  cmp_valid;
    logic [addr_width-1:0] cmp_addr;
    int                    check_errors;
    int                    compare_errors;
    longint                read_sum;
    int                    done_count;
    int                    cycle_count;
    int                    tests_passed;
    int                    tests_failed;

    lbm_solver #(
        .GRID_WIDTH (grid_width),
        .GRID_HEIGHT(grid_height)
    ) lbm_solver_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd      (cmd),
        .ready    (ready),
        .busy     (busy),
        .done     (done),
        .barriers (barriers),
        .init_pops(init_pops),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // reference model

    // direction whose step is the negated step of d
    function automatic int dir_reverse(input int d);
        int k;
        dir_reverse = 0;
        for (k = 0; k < 9; k++)
        begin
            if (ref_dx[k] == -ref_dx[d] && ref_dy[k] == -ref_dy[d])
                dir_reverse = k;
        end
    endfunction

    // one pull stream pass with bounce-back
    function automatic grid_t lbm_ref_step(input grid_t g, input logic [cells-1:0] bar);
        grid_t nxt;
        int    c;
        int    sx;
        int    sy;
        for (int y = 0; y < grid_height; y++)
        begin
            for (int x = 0; x < grid_width; x++)
            begin
                c = y * grid_width + x;
                for (int d = 0; d < 9; d++)
                begin
                    sx = x - ref_dx[d];
                    sy = y - ref_dy[d];
                    if (bar[c])
                        nxt[c].by_dir[d] = '0;
                    else if (d == 0)
                        nxt[c].by_dir[d] = g[c].by_dir[0];
                    // source off grid or solid so own opposite reflects
                    else if (sx < 0 || sx >= grid_width || sy < 0 || sy >= grid_height)
                        nxt[c].by_dir[d] = g[c].by_dir[dir_reverse(d)];
                    else if (bar[sy * grid_width + sx])
                        nxt[c].by_dir[d] = g[c].by_dir[dir_reverse(d)];
                    else
                        nxt[c].by_dir[d] = g[sy * grid_width + sx].by_dir[d];
                end
            end
        end
        return nxt;
    endfunction

    // sum of every population over fluid cells
    function automatic longint fluid_mass(input grid_t g, input logic [cells-1:0] bar);
        longint total;
        total = 0;
        for (int c = 0; c < cells; c++)
        begin
            if (!bar[c])
            begin
                for (int d = 0; d < 9; d++)
                    total += longint'(g[c].by_dir[d]);
            end
        end
        return total;
    endfunction

    ////////////////////
    // comparing process

    // read address delayed to line up with rd_data
    always @(posedge clk)
    begin
        cmp_valid <= rd_req;
        cmp_addr  <= rd_addr;
    end

    always @(negedge clk)
    begin
        if (cmp_valid === 1'b1)
        begin
            for (int d = 0; d < 9; d++)
            begin
                if (rd_data.by_dir[d] !== model[cmp_addr].by_dir[d])
                begin
                    $display("error: rd_data cell %0d dir %0d got %h expected %h",
                             cmp_addr, d, rd_data.by_dir[d], model[cmp_addr].by_dir[d]);
                    compare_errors++;
                end
                // mass over fluid cells only
                if (!barriers[cmp_addr])
                    read_sum += longint'(rd_data.by_dir[d]);
            end
        end
    end

    always @(negedge clk)
    begin
        if (rst_n && done)
            done_count++;
    end

    // run limit
    initial
    begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the engine never finished", cycle_count);
        $display("Simulation failed");
        $finish;
    end

    ////////////////////
    // helper tasks

    function automatic int error_total();
        return check_errors + compare_errors;
    endfunction

    // issue a command and wait for done
    task automatic run_command(input cmd_op_e op, input logic [15:0] steps,
                               input bit hold_other, input int passes);
        int cycles;
        @(negedge clk);
        if (!ready)
        begin
            $display("engine was not ready when a command was issued");
            check_errors++;
        end
        cmd.valid = 1'b1;
        cmd.op    = op;
        cmd.steps = steps;
        @(negedge clk);
        // second command stays on the bus while busy
        if (hold_other)
        begin
            cmd.op    = op_step;
            cmd.steps = 16'd2;
        end
        else
            cmd.valid = 1'b0;
        cycles = 0;
        while (!done)
        begin
            @(negedge clk);
            cycles++;
            // dropped before ready can rise again
            if (cycles == cells)
                cmd.valid = 1'b0;
        end
        // latency fixed at CELLS+3 per pass
        if (cycles != passes * (cells + 3))
        begin
            $display("error: done latency got %h expected %h", cycles, passes * (cells + 3));
            check_errors++;
        end
    endtask

    // one address per cycle with the comparer a cycle behind
    task automatic read_and_compare();
        // fluid mass of this read-back only
        read_sum = 0;
        for (int i = 0; i < cells; i++)
        begin
            @(negedge clk);
            rd_addr = addr_width'(i);
            rd_req  = 1'b1;
        end
        @(negedge clk);
        rd_req = 1'b0;
        @(negedge clk);
    endtask

    task automatic report_test(input string name, input int errors_before);
        int new_errors;
        new_errors = error_total() - errors_before;
        if (new_errors == 0)
        begin
            tests_passed++;
            $display("test %s passed", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, new_errors);
        end
    endtask

    ////////////////////
    // test sequence

    initial
    begin
        int          err_mark;
        int          done_before;
        longint      sum_before;
        int          total_errors;
        int          chk_failures;
        void'($urandom(32'h632ebfdc));
        rst_n          = 1'b0;
        cmd            = '0;
        barriers       = '0;
        init_pops      = '0;
        rd_addr        = '0;
        rd_req         = 1'b0;
        model          = '0;
        check_errors   = 0;
        compare_errors = 0;
        read_sum       = 0;
        done_count     = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        // three rising edges in reset
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // reset state
        err_mark = error_total();
        @(negedge clk);
        if (ready !== 1'b1 || busy !== 1'b0 || done !== 1'b0)
        begin
            $display("error: ready busy done got %h %h %h expected 1 0 0", ready, busy, done);
            check_errors++;
        end
        report_test("reset", err_mark);

        // about one cell in five solid plus a fixed one next to a corner
        for (int i = 0; i < cells; i++)
            barriers[i] = ($urandom % 5 == 0);
        barriers[grid_width + 1] = 1'b1;
        barriers[0]              = 1'b0;
        init_pops.named.rest = pop_t'($urandom);
        init_pops.named.n    = pop_t'($urandom);
        init_pops.named.ne   = pop_t'($urandom);
        init_pops.named.e    = pop_t'($urandom);
        init_pops.named.se   = pop_t'($urandom);
        init_pops.named.s    = pop_t'($urandom);
        init_pops.named.sw   = pop_t'($urandom);
        init_pops.named.w    = pop_t'($urandom);
        init_pops.named.nw   = pop_t'($urandom);

        // init pass
        err_mark = error_total();
        for (int c = 0; c < cells; c++)
            model[c] = barriers[c] ? cell_pops_u'('0) : init_pops;
        run_command(op_init, 16'd0, 1'b0, 1);
        read_and_compare();
        report_test("init", err_mark);

        // single step
        err_mark = error_total();
        model    = lbm_ref_step(model, barriers);
        run_command(op_step, 16'd1, 1'b0, 1);
        read_and_compare();
        report_test("one step", err_mark);

        // three steps in one command
        err_mark = error_total();
        for (int s = 0; s < 3; s++)
            model = lbm_ref_step(model, barriers);
        run_command(op_step, 16'd3, 1'b0, 3);
        read_and_compare();
        report_test("three steps", err_mark);

        // mass over fluid cells survives a step
        err_mark   = error_total();
        sum_before = fluid_mass(model, barriers);
        model      = lbm_ref_step(model, barriers);
        run_command(op_step, 16'd1, 1'b0, 1);
        read_and_compare();
        if (read_sum != sum_before)
        begin
            $display("error: read_sum got %h expected %h", read_sum, sum_before);
            check_errors++;
        end
        report_test("mass", err_mark);

        // second command held while busy
        err_mark    = error_total();
        done_before = done_count;
        model       = lbm_ref_step(model, barriers);
        run_command(op_step, 16'd1, 1'b1, 1);
        repeat (5) @(negedge clk);
        if (done_count - done_before != 1)
        begin
            $display("error: done pulses got %h expected 1", done_count - done_before);
            check_errors++;
        end
        if (ready !== 1'b1)
        begin
            $display("held command was taken after the run finished");
            check_errors++;
        end
        read_and_compare();
        report_test("busy command ignored", err_mark);

        chk_failures = lbm_solver_inst.lbm_step_fsm_inst.lbm_solver_chk_inst.assert_failures;
        total_errors = error_total() + chk_failures;
        $display("tests passed %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_passed, tests_failed, total_errors, chk_failures);
        if (tests_failed == 0 && total_errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- tb/lbm_solver_chk.sv
`timescale 1ns/1ps

module lbm_solver_chk (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cmd_valid,
    input  logic                     ready,
    input  logic                     busy,
    input  logic                     done,
    input  lbm_ctrl_pkg::seq_state_e state
);
    import lbm_ctrl_pkg::*;

    // running count of fired assertions
    int assert_failures = 0;

    // done is a single cycle pulse
    done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else
    begin
        $error("done stayed high for a second cycle");
        assert_failures++;
    end

    // accepted command leaves idle and drops ready while busy
    ready_busy: assert property (@(posedge clk) disable iff (!rst_n)
        ready && cmd_valid |=> busy && !ready)
    else
    begin
        $error("accepted command did not move the engine from ready to busy");
        assert_failures++;
    end

    // pipeline drained before the level flips
    swap_after_drain: assert property (@(posedge clk) disable iff (!rst_n)
        state == swap |-> $past(state) == drain && $past(state, 2) == drain)
    else
    begin
        $error("swap entered without two drain cycles before it");
        assert_failures++;
    end

endmodule

bind lbm_step_fsm lbm_solver_chk lbm_solver_chk_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_valid(cmd.valid),
    .ready    (ready),
    .busy     (busy),
    .done     (done),
    .state    (state_q)
);

//--- source/lbm_solver.sv
`timescale 1ns/1ps

module lbm_solver #(
    parameter int  GRID_WIDTH  = 8,
    parameter int  GRID_HEIGHT = 8,
    localparam int cells       = GRID_WIDTH * GRID_HEIGHT,
    localparam int addr_width  = $clog2(cells)
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  lbm_ctrl_pkg::cmd_t          cmd,
    output logic                        ready,
    output logic                        busy,
    output logic                        done,
    input  logic [cells-1:0]            barriers,
    input  lbm_lattice_pkg::cell_pops_u init_pops,
    input  logic [addr_width-1:0]       rd_addr,
    output lbm_lattice_pkg::cell_pops_u rd_data
);
    import lbm_lattice_pkg::*;
    import lbm_ctrl_pkg::*;

    // sequencer to scan and datapath
    logic                       scan_start;
    logic                       scan_en;
    scan_pos_t                  pos;
    cmd_op_e                    pass_mode;
    logic                       cur_level;
    // stream unit to memory
    logic [8:0][addr_width-1:0] nbr_addr;
    logic [addr_width-1:0]      own_addr;
    cell_pops_u                 nbr_data;
    cell_pops_u                 own_data;
    logic                       wr_en;
    logic [addr_width-1:0]      wr_addr;
    cell_pops_u                 wr_data;

    lbm_step_fsm #(
        .GRID_WIDTH (GRID_WIDTH),
        .GRID_HEIGHT(GRID_HEIGHT)
    ) lbm_step_fsm_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .scan_last (pos.last),
        .ready     (ready),
        .busy      (busy),
        .done      (done),
        .scan_start(scan_start),
        .scan_en   (scan_en),
        .pass_mode (pass_mode),
        .cur_level (cur_level)
    );

    cell_scan_counter #(
        .GRID_WIDTH (GRID_WIDTH),
        .GRID_HEIGHT(GRID_HEIGHT)
    ) cell_scan_counter_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .scan_start(scan_start),
        .scan_en   (scan_en),
        .pos       (pos)
    );

    stream_bounce_unit #(
        .GRID_WIDTH (GRID_WIDTH),
        .GRID_HEIGHT(GRID_HEIGHT)
    ) stream_bounce_unit_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .pos      (pos),
        .pass_mode(pass_mode),
        .barriers (barriers),
        .init_pops(init_pops),
        .nbr_addr (nbr_addr),
        .own_addr (own_addr),
        .nbr_data (nbr_data),
        .own_data (own_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    lattice_memory #(
        .GRID_WIDTH (GRID_WIDTH),
        .GRID_HEIGHT(GRID_HEIGHT)
    ) lattice_memory_inst (
        .clk      (clk),
        .cur_level(cur_level),
        .nbr_addr (nbr_addr),
        .own_addr (own_addr),
        .rd_addr  (rd_addr),
        .ready    (ready),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .nbr_data (nbr_data),
        .own_data (own_data),
        .rd_data  (rd_data)
    );

endmodule

//--- source/lattice_memory.sv
`timescale 1ns/1ps

module lattice_memory #(
    parameter int  GRID_WIDTH  = 8,
    parameter int  GRID_HEIGHT = 8,
    localparam int cells       = GRID_WIDTH * GRID_HEIGHT,
    localparam int addr_width  = $clog2(cells)
) (
    input  logic                        clk,
    input  logic                        cur_level,
    input  logic [8:0][addr_width-1:0]  nbr_addr,
    input  logic [addr_width-1:0]       own_addr,
    input  logic [addr_width-1:0]       rd_addr,
    input  logic                        ready,
    input  logic                        wr_en,
    input  logic [addr_width-1:0]       wr_addr,
    input  lbm_lattice_pkg::cell_pops_u wr_data,
    output lbm_lattice_pkg::cell_pops_u nbr_data,
    output lbm_lattice_pkg::cell_pops_u own_data,
    output lbm_lattice_pkg::cell_pops_u rd_data
);
    import lbm_lattice_pkg::*;

    localparam int slot_width = $clog2(2 * cells);

    // one array per direction, level 1 in the upper half
    pop_t                  ram [9][2*cells];
    cell_pops_u            nbr_q;
    cell_pops_u            own_q;
    logic [addr_width-1:0] port_b_addr;

    function automatic logic [slot_width-1:0] slot(input logic level,
                                                   input logic [addr_width-1:0] addr);
        slot = level ? slot_width'(addr) + slot_width'(cells) : slot_width'(addr);
    endfunction

    // host read-back shares the own-cell port while idle
    assign port_b_addr = ready ? rd_addr : own_addr;

    // reads from current level, writes into the next one
    always_ff @(posedge clk)
    begin
        for (int d = 0; d < 9; d++)
        begin
            if (wr_en)
                ram[d][slot(~cur_level, wr_addr)] <= wr_data.by_dir[d];
            nbr_q.by_dir[d] <= ram[d][slot(cur_level, nbr_addr[d])];
            own_q.by_dir[d] <= ram[d][slot(cur_level, port_b_addr)];
        end
    end

    assign nbr_data = nbr_q;
    assign own_data = own_q;
    assign rd_data  = own_q;

endmodule

//--- source/stream_bounce_unit.sv
`timescale 1ns/1ps

module stream_bounce_unit #(
    parameter int  GRID_WIDTH  = 8,
    parameter int  GRID_HEIGHT = 8,
    localparam int cells       = GRID_WIDTH * GRID_HEIGHT,
    localparam int addr_width  = $clog2(cells)
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  lbm_ctrl_pkg::scan_pos_t      pos,
    input  lbm_ctrl_pkg::cmd_op_e        pass_mode,
    input  logic [cells-1:0]             barriers,
    input  lbm_lattice_pkg::cell_pops_u  init_pops,
    output logic [8:0][addr_width-1:0]   nbr_addr,
    output logic [addr_width-1:0]        own_addr,
    input  lbm_lattice_pkg::cell_pops_u  nbr_data,
    input  lbm_lattice_pkg::cell_pops_u  own_data,
    output logic                         wr_en,
    output logic [addr_width-1:0]        wr_addr,
    output lbm_lattice_pkg::cell_pops_u  wr_data
);
    import lbm_lattice_pkg::*;
    import lbm_ctrl_pkg::*;

    logic                  scan_valid;
    logic [8:0]            blocked;
    logic                  s1_valid;
    logic                  s1_barrier;
    logic [8:0]            s1_blocked;
    logic [addr_width-1:0] s1_addr;
    cmd_op_e               s1_mode;
    cell_pops_u            next_pops;

    ////////////////////
    // stage 1, addressing

    assign own_addr   = pos.index[addr_width-1:0];
    assign scan_valid = (pos.index < cell_index_t'(cells));

    // pull source for direction d sits at (x - dx, y - dy)
    always_comb
    begin
        int sx;
        int sy;
        for (int d = 0; d < 9; d++)
        begin
            sx = int'(pos.x) - int'(dir_dx[d]);
            sy = int'(pos.y) - int'(dir_dy[d]);
            if (sx < 0 || sx >= GRID_WIDTH || sy < 0 || sy >= GRID_HEIGHT)
            begin
                // off the grid, wall bounce
                nbr_addr[d] = own_addr;
                blocked[d]  = 1'b1;
            end
            else
            begin
                nbr_addr[d] = addr_width'(sy * GRID_WIDTH + sx);
                // solid source bounces too
                blocked[d]  = barriers[nbr_addr[d]];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            s1_valid <= 1'b0;
        else
            s1_valid <= scan_valid;
    end

    // lines up with the memory read data
    always_ff @(posedge clk)
    begin
        s1_addr    <= own_addr;
        s1_barrier <= barriers[own_addr];
        s1_blocked <= blocked;
        s1_mode    <= pass_mode;
    end

    ////////////////////
    // stage 2, write data

    always_comb
    begin
        for (int d = 0; d < 9; d++)
        begin
            if (s1_barrier)
                next_pops.by_dir[d] = '0;
            else if (s1_mode == op_init)
                next_pops.by_dir[d] = init_pops.by_dir[d];
            // rest never moves
            else if (dir_e'(d) == d_rest)
                next_pops.by_dir[d] = own_data.by_dir[d_rest];
            // reflected back into this cell
            else if (s1_blocked[d])
                next_pops.by_dir[d] = own_data.by_dir[dir_opposite[d]];
            else
                next_pops.by_dir[d] = nbr_data.by_dir[d];
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            wr_en <= 1'b0;
        else
            wr_en <= s1_valid;
    end

    always_ff @(posedge clk)
    begin
        wr_addr <= s1_addr;
        wr_data <= next_pops;
    end

endmodule

//--- source/cell_scan_counter.sv
`timescale 1ns/1ps

module cell_scan_counter #(
    parameter int GRID_WIDTH  = 8,
    parameter int GRID_HEIGHT = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    scan_start,
    input  logic                    scan_en,
    output lbm_ctrl_pkg::scan_pos_t pos
);
    import lbm_ctrl_pkg::*;

    localparam int cells = GRID_WIDTH * GRID_HEIGHT;

    cell_index_t index_q;
    coord_t      x_q;
    coord_t      y_q;
    logic        x_wrap;

    // end of row
    assign x_wrap = (x_q == coord_t'(GRID_WIDTH - 1));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            // parked one past the final cell
            index_q <= cell_index_t'(cells);
            x_q     <= '0;
            y_q     <= coord_t'(GRID_HEIGHT);
        end
        else if (scan_start)
        begin
            index_q <= '0;
            x_q     <= '0;
            y_q     <= '0;
        end
        else if (scan_en)
        begin
            index_q <= index_q + 1'b1;
            // column wraps into next row
            x_q     <= x_wrap ? '0 : x_q + 1'b1;
            y_q     <= x_wrap ? y_q + 1'b1 : y_q;
        end
    end

    assign pos.index = index_q;
    assign pos.x     = x_q;
    assign pos.y     = y_q;
    // final cell, bottom right corner
    assign pos.last  = x_wrap && (y_q == coord_t'(GRID_HEIGHT - 1));

endmodule

//--- source/lbm_step_fsm.sv
`timescale 1ns/1ps

module lbm_step_fsm #(
    parameter int GRID_WIDTH  = 8,
    parameter int GRID_HEIGHT = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  lbm_ctrl_pkg::cmd_t    cmd,
    input  logic                  scan_last,
    output logic                  ready,
    output logic                  busy,
    output logic                  done,
    output logic                  scan_start,
    output logic                  scan_en,
    output lbm_ctrl_pkg::cmd_op_e pass_mode,
    output logic                  cur_level
);
    import lbm_ctrl_pkg::*;

    localparam int max_side = 2 ** coord_bits - 1;

    seq_state_e  state_q;
    seq_state_e  state_d;
    cmd_op_e     mode_q;
    logic [15:0] steps_left_q;
    logic        drain_cnt_q;
    logic        level_q;
    logic        done_q;
    logic        accept;
    logic        last_pass;

    // scan coordinates must hold the grid
    if (GRID_WIDTH > max_side || GRID_HEIGHT > max_side)
    begin : g_grid_range
        $error("grid size outside the scan coordinate range");
    end

    // commands only taken when idle, never queued
    assign accept    = cmd.valid && (state_q == idle);
    // init is always a single pass
    assign last_pass = (mode_q == op_init) || (steps_left_q <= 16'd1);

    ////////////////////
    // next state

    always_comb
    begin
        state_d    = state_q;
        scan_start = 1'b0;
        case (state_q)
            idle:
            begin
                if (accept)
                begin
                    scan_start = 1'b1;
                    state_d    = (cmd.op == op_init) ? init_scan : step_scan;
                end
            end
            init_scan, step_scan:
            begin
                if (scan_last)
                    state_d = drain;
            end
            drain:
            begin
                // wait out the two cells still in the stream pipeline
                if (drain_cnt_q)
                    state_d = (mode_q == op_step && steps_left_q == '0) ? idle : swap;
            end
            swap:
            begin
                if (last_pass)
                    state_d = idle;
                else
                begin
                    scan_start = 1'b1;
                    state_d    = step_scan;
                end
            end
            default:
            begin
                state_d = idle;
            end
        endcase
    end

    ////////////////////
    // state registers

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q      <= idle;
            mode_q       <= op_init;
            steps_left_q <= '0;
            drain_cnt_q  <= 1'b0;
            level_q      <= 1'b0;
            done_q       <= 1'b0;
        end
        else
        begin
            state_q     <= state_d;
            drain_cnt_q <= (state_q == drain) && !drain_cnt_q;
            // pulse lands in the cycle idle is reached
            done_q      <= (state_q != idle) && (state_d == idle);
            if (accept)
            begin
                mode_q       <= cmd.op;
                steps_left_q <= (cmd.op == op_step) ? cmd.steps : '0;
            end
            // next level becomes current
            if (state_q == swap)
            begin
                level_q <= ~level_q;
                if (steps_left_q != '0)
                    steps_left_q <= steps_left_q - 16'd1;
            end
        end
    end

    assign ready     = (state_q == idle);
    assign busy      = (state_q != idle);
    assign done      = done_q;
    assign scan_en   = (state_q == init_scan) || (state_q == step_scan);
    assign pass_mode = mode_q;
    assign cur_level = level_q;

endmodule

//--- source/lbm_ctrl_pkg.sv
package lbm_ctrl_pkg;

    // host command
    typedef enum logic {
        op_init,
        op_step
    } cmd_op_e;

    typedef struct packed {
        logic        valid;
        cmd_op_e     op;
        logic [15:0] steps;
    } cmd_t;

    // sequencer states
    typedef enum logic [2:0] {
        idle,
        init_scan,
        step_scan,
        drain,
        swap
    } seq_state_e;

    // scan position, fields cover grids up to 255 cells a side
    localparam int coord_bits = 8;

    typedef logic [coord_bits-1:0]   coord_t;
    typedef logic [2*coord_bits-1:0] cell_index_t;

    // index equal to the cell count means no scan in flight
    typedef struct packed {
        cell_index_t index;
        coord_t      x;
        coord_t      y;
        logic        last;
    } scan_pos_t;

endpackage

//--- source/lbm_lattice_pkg.sv
package lbm_lattice_pkg;

    ////////////////////
    // population values

    // unsigned fixed point, one value per direction per cell
    localparam int pop_width = 16;

    typedef logic [pop_width-1:0] pop_t;

    // rest first, then clockwise from north
    typedef enum logic [3:0] {
        d_rest,
        d_n,
        d_ne,
        d_e,
        d_se,
        d_s,
        d_sw,
        d_w,
        d_nw
    } dir_e;

    ////////////////////
    // direction tables

    localparam dir_e dir_opposite [9] = '{d_rest, d_s, d_sw, d_w, d_nw, d_n, d_ne, d_e, d_se};

    // column step, east is +1
    localparam logic signed [1:0] dir_dx [9] = '{
        2'sd0, 2'sd0, 2'sd1, 2'sd1, 2'sd1, 2'sd0, -2'sd1, -2'sd1, -2'sd1
    };

    // row step, north is the row above so -1
    localparam logic signed [1:0] dir_dy [9] = '{
        2'sd0, -2'sd1, -2'sd1, 2'sd0, 2'sd1, 2'sd1, 2'sd1, 2'sd0, -2'sd1
    };

    ////////////////////
    // cell words

    // msb first, so field order is the reverse of dir_e
    typedef struct packed {
        pop_t nw;
        pop_t w;
        pop_t sw;
        pop_t s;
        pop_t se;
        pop_t e;
        pop_t ne;
        pop_t n;
        pop_t rest;
    } cell_named_t;

    // names for the host side, by_dir[dir_e] for the datapath
    typedef union packed {
        cell_named_t named;
        pop_t [8:0]  by_dir;
    } cell_pops_u;

endpackage
